/* bench/qed_mem_assert.sv */
`timescale 1ns/1ps

module qed_mem_assert import qed_mem_pkg::*; (
     input  logic     clk
    ,input  logic     rst
    ,input  mem_req_t req
    ,input  logic     ready
    ,input  mem_rsp_t rsp
    ,input  logic     req_drop
    ,input  logic     pwr_enable_b_in
    ,input  logic     pwr_enable_b_out
);

    // A request with a strobe set that the input side takes in
    logic accepted_rd;
    logic accepted_any;

    // Count of failed assertions
    int fail_count = 0;

    assign accepted_rd  = req.re & ready;
    assign accepted_any = (req.re | req.we) & ready;

    // **************************************************************************
    // Read latency, drop flag and power chain
    // **************************************************************************

    // Three register stages sit between the strobe and the response
    a_rd_to_valid: assert property (@(posedge clk) disable iff (rst)
        accepted_rd |-> ##3 rsp.valid)
        else begin
            fail_count++;
            $error("accepted read gave no response three cycles later");
        end

    // Every response must come from a read taken in three cycles before
    a_valid_from_rd: assert property (@(posedge clk) disable iff (rst)
        rsp.valid |-> $past(accepted_rd, 3))
        else begin
            fail_count++;
            $error("response without a matching accepted read");
        end

    a_no_drop_after_accept: assert property (@(posedge clk) disable iff (rst)
        accepted_any |=> !req_drop)
        else begin
            fail_count++;
            $error("drop flag raised for an accepted request");
        end

    // The chain registers hold their reset value for two cycles after rst
    a_pwr_chain: assert property (@(posedge clk) disable iff (rst)
        (!$past(rst) && !$past(rst, 2)) |-> pwr_enable_b_out == $past(pwr_enable_b_in, 2))
        else begin
            fail_count++;
            $error("power enable output is not the input delayed by two cycles");
        end

endmodule

bind qed_mem_top qed_mem_assert u_assert (
     .clk              (clk)
    ,.rst              (rst)
    ,.req              (req)
    ,.ready            (ready)
    ,.rsp              (rsp)
    ,.req_drop         (req_drop)
    ,.pwr_enable_b_in  (pwr_enable_b_in)
    ,.pwr_enable_b_out (pwr_enable_b_out)
);

/* bench/qed_mem_checker.sv */
`timescale 1ns/1ps

module qed_mem_checker import qed_mem_pkg::*; (
     input  logic     clk
    ,input  logic     rst
    ,input  mem_rsp_t rsp
    ,input  logic     req_drop
    ,input  logic     pwr_enable_b_out
);

    // Words the DUT still owes, oldest first
    word_t exp_q [$];

    // Reference copy of the array, filled during the burst test
    word_t model [MEM_DEPTH];

    int drops_pending = 0;
    int test_id = 0;
    int test_checks = 0;
    int test_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int total_checks = 0;
    int total_errors = 0;

    task automatic note_check(input logic bad);
        test_checks++;
        total_checks++;
        if (bad) begin
            test_errors++;
            total_errors++;
        end
    endtask

    // **************************************************************************
    // Calls from the testbench
    // **************************************************************************

    task automatic start_test(input int id);
        test_id = id;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic expect_word(input word_t w);
        exp_q.push_back(w);
    endtask

    task automatic expect_drop();
        drops_pending++;
    endtask

    task automatic model_write(input addr_t a, input word_t w);
        model[a] = w;
    endtask

    task automatic expect_model(input addr_t a);
        exp_q.push_back(model[a]);
    endtask

    function automatic int outstanding();
        return exp_q.size() + drops_pending;
    endfunction

    function automatic int error_count();
        return total_errors;
    endfunction

    // Outputs right after reset, power still off
    task automatic check_reset_state();
        note_check(rsp.valid !== 1'b0);
        if (rsp.valid !== 1'b0) $display("Error: rsp.valid expected 0x0 got 0x%h", rsp.valid);
        note_check(req_drop !== 1'b0);
        if (req_drop !== 1'b0) $display("Error: req_drop expected 0x0 got 0x%h", req_drop);
        note_check(pwr_enable_b_out !== 1'b1);
        if (pwr_enable_b_out !== 1'b1) begin
            $display("Error: pwr_enable_b_out expected 0x1 got 0x%h", pwr_enable_b_out);
        end
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errors != 0) tests_failed++;
        $display("Test %0d %s: %0d checks, %0d errors", test_id,
                 (test_errors == 0) ? "passed" : "failed", test_checks, test_errors);
    endtask

    task automatic report();
        $display("Summary: %0d tests run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, total_checks, total_errors);
    endtask

    // **************************************************************************
    // Response monitor
    // **************************************************************************

    // Outputs only change after the edge, so the values seen here are stable
    always @(posedge clk) begin
        word_t want;
        if (!rst) begin
            if (rsp.valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    note_check(1'b1);
                    $display("A response came with no read outstanding in test %0d", test_id);
                end else begin
                    want = exp_q.pop_front();
                    note_check(rsp.rdata !== want);
                    if (rsp.rdata !== want) begin
                        $display("Error: rsp.rdata expected 0x%h got 0x%h", want, rsp.rdata);
                    end
                end
            end
            if (req_drop === 1'b1) begin
                note_check(drops_pending == 0);
                if (drops_pending == 0) begin
                    $display("A request was dropped unexpectedly in test %0d", test_id);
                end else begin
                    drops_pending--;
                end
            end
        end
    end

endmodule

/* bench/qed_mem_tb.sv */
`timescale 1ns/1ps

module qed_mem_tb import qed_mem_pkg::*; ();

    localparam int CLK_HALF     = 20;
    localparam int RESET_CYCLES = 8;
    localparam int WAIT_LIMIT   = 200;
    localparam int VEC_FIELDS   = 5;
    localparam int VEC_MAX      = 64;

    logic     clk;
    logic     rst;
    mem_req_t req;
    logic     pgcb_isol_en;
    logic     pwr_enable_b_in;
    logic     ip_reset_b;
    logic     fscan_rstbypen;
    logic     fscan_byprst_b;
    mem_rsp_t rsp;
    logic     pwr_enable_b_out;
    logic     req_drop;

    // Five fields per operation: test, op, address, data, expected word
    logic [143:0] vec [VEC_MAX*VEC_FIELDS];

    logic [15:0] lfsr_state;
    logic        timed_out;
    logic        bad_vector;

    qed_mem_top #(
        .SYNC_STAGES (SYNC_STAGES_DEF)
    ) dut0 (
         .clk              (clk)
        ,.rst              (rst)
        ,.req              (req)
        ,.pgcb_isol_en     (pgcb_isol_en)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.ip_reset_b       (ip_reset_b)
        ,.fscan_rstbypen   (fscan_rstbypen)
        ,.fscan_byprst_b   (fscan_byprst_b)
        ,.rsp              (rsp)
        ,.pwr_enable_b_out (pwr_enable_b_out)
        ,.req_drop         (req_drop)
    );

    qed_mem_checker chk0 (
         .clk              (clk)
        ,.rst              (rst)
        ,.rsp              (rsp)
        ,.req_drop         (req_drop)
        ,.pwr_enable_b_out (pwr_enable_b_out)
    );

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    // **************************************************************************
    // Stimulus helpers
    // **************************************************************************

    // Galois LFSR with taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic lfsr_word(output word_t w);
        for (int b = 0; b < WORD_W; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w[b] = lfsr_state[0];
        end
    endtask

    task automatic drive_req(input logic rd, input logic wr, input addr_t a, input word_t d);
        @(posedge clk);
        req <= '{re: rd, we: wr, addr: a, wdata: d};
    endtask

    task automatic drive_idle();
        drive_req(1'b0, 1'b0, '0, '0);
    endtask

    // Wait until every read has answered and every drop has shown up
    task automatic wait_drained();
        int cnt;
        cnt = 0;
        while (chk0.outstanding() != 0 && cnt < WAIT_LIMIT) begin
            @(posedge clk);
            cnt++;
        end
        if (chk0.outstanding() != 0) begin
            $display("Timed out waiting for %0d outstanding responses", chk0.outstanding());
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_power(input logic val);
        int cnt;
        cnt = 0;
        while (pwr_enable_b_out !== val && cnt < WAIT_LIMIT) begin
            @(posedge clk);
            cnt++;
        end
        if (pwr_enable_b_out !== val) begin
            $display("Timed out waiting for the power enable chain to settle");
            timed_out = 1'b1;
        end
    endtask

    task automatic settle(input int cycles);
        for (int k = 0; k < cycles; k++) begin
            @(posedge clk);
        end
    endtask

    // Control inputs change only with no traffic in flight
    task automatic set_control(input addr_t id, input logic val);
        drive_idle();
        wait_drained();
        @(posedge clk);
        case (id)
            11'd0: pwr_enable_b_in <= val;
            11'd1: pgcb_isol_en <= val;
            11'd2: ip_reset_b <= val;
            11'd3: fscan_rstbypen <= val;
            11'd4: fscan_byprst_b <= val;
            default: begin
                $display("Vector names control input %0d, which does not exist", id);
                bad_vector = 1'b1;
            end
        endcase
        if (id == 11'd0) wait_power(val);
        // The synchronizer releases a fixed number of cycles after ip_reset_b
        if (id == 11'd2 && val) settle(SYNC_STAGES_DEF);
    endtask

    // Back-to-back writes of LFSR data, then back-to-back reads of them
    task automatic run_burst(input addr_t base, input int count);
        word_t w;
        for (int k = 0; k < count; k++) begin
            lfsr_word(w);
            drive_req(1'b0, 1'b1, base + addr_t'(k), w);
            chk0.model_write(base + addr_t'(k), w);
        end
        for (int k = 0; k < count; k++) begin
            drive_req(1'b1, 1'b0, base + addr_t'(k), '0);
            chk0.expect_model(base + addr_t'(k));
        end
    endtask

    task automatic close_test();
        drive_idle();
        wait_drained();
        chk0.finish_test();
    endtask

    // **************************************************************************
    // Main sequence
    // **************************************************************************

    initial begin
        int n_ops;
        int cur_test;
        logic [3:0] op;
        addr_t a;
        word_t d;
        word_t e;

        rst = 1'b1;
        // Strobes and a low power enable during reset leave only the reset
        // itself to keep the outputs quiet
        req = '{re: 1'b1, we: 1'b1, addr: '0, wdata: '0};
        pgcb_isol_en = 1'b0;
        pwr_enable_b_in = 1'b0;
        ip_reset_b = 1'b0;
        fscan_rstbypen = 1'b0;
        fscan_byprst_b = 1'b0;
        timed_out = 1'b0;
        bad_vector = 1'b0;
        lfsr_state = 16'd64;
        n_ops = 0;
        cur_test = -1;
        $readmemh("bench/qed_mem_vectors.txt", vec);

        settle(RESET_CYCLES);
        rst <= 1'b0;
        req <= '0;
        @(posedge clk);
        chk0.check_reset_state();

        // Let the power enable run down the bank chain and release the IP reset
        ip_reset_b <= 1'b1;
        wait_power(1'b0);
        settle(SYNC_STAGES_DEF);

        for (int i = 0; i < VEC_MAX && !timed_out; i++) begin
            op = vec[i*VEC_FIELDS+1][3:0];
            if ($isunknown(vec[i*VEC_FIELDS]) || op == 4'hF) break;
            a = vec[i*VEC_FIELDS+2][ADDR_W-1:0];
            d = vec[i*VEC_FIELDS+3][WORD_W-1:0];
            e = vec[i*VEC_FIELDS+4][WORD_W-1:0];
            if (int'(vec[i*VEC_FIELDS]) != cur_test) begin
                if (cur_test >= 0) close_test();
                cur_test = int'(vec[i*VEC_FIELDS]);
                chk0.start_test(cur_test);
            end
            case (op)
                4'h1: drive_req(1'b0, 1'b1, a, d);
                4'h2: begin
                    drive_req(1'b1, 1'b0, a, '0);
                    chk0.expect_word(e);
                end
                4'h3: begin
                    drive_req(1'b0, 1'b1, a, d);
                    chk0.expect_drop();
                end
                4'h4: begin
                    drive_req(1'b1, 1'b0, a, '0);
                    chk0.expect_drop();
                end
                // Read and write in one cycle give back the old word
                4'h5: begin
                    drive_req(1'b1, 1'b1, a, d);
                    chk0.expect_word(e);
                end
                4'h6: set_control(a, d[0]);
                4'h7: run_burst(a, int'(d));
                default: begin
                    $display("Vector line %0d holds unknown operation %0h", i, op);
                    bad_vector = 1'b1;
                end
            endcase
            n_ops++;
        end
        if (cur_test >= 0 && !timed_out) close_test();
        if (n_ops == 0) $display("No operations were read from the vector file");
        if (dut0.u_assert.fail_count != 0) begin
            $display("%0d assertion failures were reported", dut0.u_assert.fail_count);
        end
        chk0.report();

        if (timed_out || bad_vector || n_ops == 0 || chk0.error_count() != 0
                || dut0.u_assert.fail_count != 0) begin
            $display("TESTS FAILED");
        end else begin
            $display("TESTS PASSED");
        end
        $finish;
    end

endmodule

/* bench/qed_mem_vectors.txt */
// Columns: test, op, address, data, expected word (all hex)
// Ops: 1 write, 2 read, 3 dropped write, 4 dropped read, 5 read with write, 6 control, 7 burst, F end
01 1 000 7FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF 0
01 1 001 40000000000000000000000000000000000 0
01 1 002 600000000000000000 0
01 1 7FF 3FFFFFFFFFFFFFFFFF 0
01 1 400 5A5A5A5A5A5A5A5A5A5A5A5A5A5A5A5A5A5 0
01 2 000 0 7FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
01 2 001 0 40000000000000000000000000000000000
01 2 002 0 600000000000000000
01 2 7FF 0 3FFFFFFFFFFFFFFFFF
01 2 400 0 5A5A5A5A5A5A5A5A5A5A5A5A5A5A5A5A5A5
02 7 100 40 0
03 6 000 1 0
03 3 000 3C3C3C3C3C3C3C3C3C3C3C3C3C3C3C3C3C3 0
03 4 001 0 0
03 6 000 0 0
03 2 000 0 7FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
03 2 001 0 40000000000000000000000000000000000
04 6 002 0 0
04 4 002 0 0
04 3 003 5A5A5A5A5A5A5A5A5A5A5A5A5A5A5A5A5A5 0
04 6 003 1 0
04 6 004 1 0
04 1 003 3C3C3C3C3C3C3C3C3C3C3C3C3C3C3C3C3C3 0
04 2 003 0 3C3C3C3C3C3C3C3C3C3C3C3C3C3C3C3C3C3
04 2 001 0 40000000000000000000000000000000000
04 6 002 1 0
04 6 003 0 0
04 6 004 0 0
05 1 010 1234 0
05 5 010 ABCD 1234
05 2 010 0 ABCD
06 6 001 1 0
06 3 002 5A5A5A5A5A5A5A5A5A5A5A5A5A5A5A5A5A5 0
06 4 400 0 0
06 6 001 0 0
06 2 002 0 600000000000000000
06 2 400 0 5A5A5A5A5A5A5A5A5A5A5A5A5A5A5A5A5A5
00 F 000 0 0

/* qed_mem_top.f */
src/qed_mem_pkg.sv
src/mem_reset_sync.sv
src/sram_bank_2048x70.sv
src/qed_mem_sram_pg_2048x139.sv
src/qed_mem_req_stage.sv
src/qed_mem_rd_stage.sv
src/qed_mem_top.sv
bench/qed_mem_checker.sv
bench/qed_mem_assert.sv
bench/qed_mem_tb.sv

/* src/mem_reset_sync.sv */
`timescale 1ns/1ps

module mem_reset_sync import qed_mem_pkg::*; #(
    parameter int SYNC_STAGES = SYNC_STAGES_DEF
) (
     input  logic clk
    ,input  logic rst_n

    // Scan control of the synchronized reset
    ,input  logic fscan_rstbypen
    ,input  logic fscan_byprst_b

    ,output logic rst_n_sync
);

    // Shift register of ones that fills up after the reset is released
    logic [SYNC_STAGES-1:0] sync_q;

    // **************************************************************************
    // Asynchronous assert, synchronous release
    // **************************************************************************

    // The whole chain drops at once when rst_n goes low
    // On release a one is shifted in from the bottom on every edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= '0;
        end else begin
            sync_q <= (sync_q << 1) | SYNC_STAGES'(1);
        end
    end

    // In scan mode the tester drives the reset directly
    // Otherwise the last flop of the chain is the synchronized reset
    assign rst_n_sync = fscan_rstbypen ? fscan_byprst_b : sync_q[SYNC_STAGES-1];

endmodule

/* src/qed_mem_pkg.sv */
package qed_mem_pkg;

    // **************************************************************************
    // Memory geometry
    // **************************************************************************

    // Word address into the 2048-entry array
    localparam int ADDR_W = 11;

    // Full word width as seen by the user of the memory
    localparam int WORD_W = 139;

    // Each bank stores one 70-bit slice of the word
    localparam int HALF_W = 70;

    // Number of entries in each bank
    localparam int MEM_DEPTH = 2048;

    // Default depth of the IP reset synchronizer
    localparam int SYNC_STAGES_DEF = 2;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;

    // The top slice holds 69 data bits and one pad bit in its msb
    typedef logic [HALF_W-1:0] half_t;

    // **************************************************************************
    // Request and response bundles
    // **************************************************************************

    // Plain level strobes with the address and write data, 152 bits in all
    typedef struct packed {
        logic  re;
        logic  we;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

    // Read response with its one-cycle valid, 140 bits in all
    typedef struct packed {
        logic  valid;
        word_t rdata;
    } mem_rsp_t;

endpackage

/* src/qed_mem_rd_stage.sv */
`timescale 1ns/1ps

module qed_mem_rd_stage import qed_mem_pkg::*; (
     input  logic     clk
    ,input  logic     rst

    // Read accepted into the banks this cycle
    ,input  logic     rd_issue

    // Read data straight out of the banks
    ,input  word_t    raw_rdata

    ,output mem_rsp_t rsp
);

    // Read strobe delayed by the bank latency
    logic  rd_pend;

    logic  valid_q;
    word_t rdata_q;

    // **************************************************************************
    // Read tracking
    // **************************************************************************

    // A read reaches the banks one cycle after rd_issue and the data
    // shows up one cycle after that, so rd_pend marks good raw_rdata
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pend <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            rd_pend <= rd_issue;
            valid_q <= rd_pend;
        end
    end

    // Capture only real read data, the word stays put between responses
    always_ff @(posedge clk) begin
        if (rd_pend) begin
            rdata_q <= raw_rdata;
        end
    end

    assign rsp = {valid_q, rdata_q};

endmodule

/* src/qed_mem_req_stage.sv */
`timescale 1ns/1ps

module qed_mem_req_stage import qed_mem_pkg::*; (
     input  logic     clk
    ,input  logic     rst

    // Request from the user and readiness of the memory
    ,input  mem_req_t req
    ,input  logic     ready

    ,output mem_req_t mem_req
    ,output logic     rd_issue
    ,output logic     req_drop
);

    // Strobes of the registered request
    logic  re_q;
    logic  we_q;

    // Address and write data of the registered request
    addr_t addr_q;
    word_t wdata_q;

    logic  drop_q;

    // A request is anything with a strobe set
    logic  req_any;

    assign req_any = req.re | req.we;

    // **************************************************************************
    // Strobes and drop flag
    // **************************************************************************

    // Strobes pass only while the memory is ready
    // A request that arrives when it is not ready is lost and flagged for a cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            re_q   <= 1'b0;
            we_q   <= 1'b0;
            drop_q <= 1'b0;
        end else begin
            re_q   <= req.re & ready;
            we_q   <= req.we & ready;
            drop_q <= req_any & ~ready;
        end
    end

    // Payload is only loaded for an accepted request
    always_ff @(posedge clk) begin
        if (ready && req_any) begin
            addr_q  <= req.addr;
            wdata_q <= req.wdata;
        end
    end

    assign mem_req  = {re_q, we_q, addr_q, wdata_q};

    // The output side uses the registered read strobe to track reads in flight
    assign rd_issue = re_q;
    assign req_drop = drop_q;

endmodule

/* src/qed_mem_sram_pg_2048x139.sv */
`timescale 1ns/1ps

module qed_mem_sram_pg_2048x139 import qed_mem_pkg::*; #(
    parameter int SYNC_STAGES = SYNC_STAGES_DEF
) (
     input  logic     clk
    ,input  logic     rst

    ,input  mem_req_t mem_req

    // Power interface
    ,input  logic     pgcb_isol_en
    ,input  logic     pwr_enable_b_in

    // IP reset and its scan bypass
    ,input  logic     ip_reset_b
    ,input  logic     fscan_rstbypen
    ,input  logic     fscan_byprst_b

    ,output word_t    raw_rdata
    ,output logic     ready
    ,output logic     pwr_enable_b_out
);

    logic  ip_reset_b_sync;

    // Power enable chain, entry 0 is the input and entry 2 leaves the wrapper
    logic [2:0] pwr_chain;

    // Read data of the low and the high bank
    half_t rdata_lo;
    half_t rdata_hi;

    // Write data of the high bank with the pad bit in the msb
    half_t wdata_hi;

    mem_reset_sync #(
        .SYNC_STAGES (SYNC_STAGES)
    ) i_ip_reset_b_sync (
         .clk            (clk)
        ,.rst_n          (ip_reset_b)
        ,.fscan_rstbypen (fscan_rstbypen)
        ,.fscan_byprst_b (fscan_byprst_b)
        ,.rst_n_sync     (ip_reset_b_sync)
    );

    // **************************************************************************
    // Two banks of 70 bits each
    // **************************************************************************

    assign pwr_chain[0] = pwr_enable_b_in;

    // Bits 138 to 70 go to the high bank, padded with a zero
    assign wdata_hi = {1'b0, mem_req.wdata[WORD_W-1:HALF_W]};

    sram_bank_2048x70 i_sram_b0 (
         .clk          (clk)
        ,.rst          (rst)
        ,.re           (mem_req.re)
        ,.we           (mem_req.we)
        ,.addr         (mem_req.addr)
        ,.wdata        (mem_req.wdata[HALF_W-1:0])
        ,.ip_reset_b   (ip_reset_b_sync)
        ,.isol_en      (pgcb_isol_en)
        ,.pwr_en_b_in  (pwr_chain[0])
        ,.rdata        (rdata_lo)
        ,.pwr_en_b_out (pwr_chain[1])
    );

    // Bank 1 powers up one cycle after bank 0
    sram_bank_2048x70 i_sram_b1 (
         .clk          (clk)
        ,.rst          (rst)
        ,.re           (mem_req.re)
        ,.we           (mem_req.we)
        ,.addr         (mem_req.addr)
        ,.wdata        (wdata_hi)
        ,.ip_reset_b   (ip_reset_b_sync)
        ,.isol_en      (pgcb_isol_en)
        ,.pwr_en_b_in  (pwr_chain[1])
        ,.rdata        (rdata_hi)
        ,.pwr_en_b_out (pwr_chain[2])
    );

    assign pwr_enable_b_out = pwr_chain[2];

    // The pad bit of the high bank is dropped when the word is put back together
    assign raw_rdata = {rdata_hi[WORD_W-HALF_W-1:0], rdata_lo};

    // Ready needs the whole chain powered, IP reset released and no isolation
    assign ready = ~pwr_chain[2] & ip_reset_b_sync & ~pgcb_isol_en;

endmodule

/* src/qed_mem_top.sv */
`timescale 1ns/1ps

module qed_mem_top import qed_mem_pkg::*; #(
    parameter int SYNC_STAGES = SYNC_STAGES_DEF
) (
     input  logic     clk
    ,input  logic     rst

    ,input  mem_req_t req

    // Power interface
    ,input  logic     pgcb_isol_en
    ,input  logic     pwr_enable_b_in

    // IP reset and scan bypass
    ,input  logic     ip_reset_b
    ,input  logic     fscan_rstbypen
    ,input  logic     fscan_byprst_b

    ,output mem_rsp_t rsp
    ,output logic     pwr_enable_b_out
    ,output logic     req_drop
);

    // Registered request going into the banks
    mem_req_t mem_req;

    // One-cycle pulse for every read sent to the banks
    logic     rd_issue;

    word_t    raw_rdata;
    logic     ready;

    // **************************************************************************
    // Input side, memory wrapper and output side
    // **************************************************************************

    qed_mem_req_stage i_req_stage (
         .clk      (clk)
        ,.rst      (rst)
        ,.req      (req)
        ,.ready    (ready)
        ,.mem_req  (mem_req)
        ,.rd_issue (rd_issue)
        ,.req_drop (req_drop)
    );

    qed_mem_sram_pg_2048x139 #(
        .SYNC_STAGES (SYNC_STAGES)
    ) i_mem (
         .clk              (clk)
        ,.rst              (rst)
        ,.mem_req          (mem_req)
        ,.pgcb_isol_en     (pgcb_isol_en)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.ip_reset_b       (ip_reset_b)
        ,.fscan_rstbypen   (fscan_rstbypen)
        ,.fscan_byprst_b   (fscan_byprst_b)
        ,.raw_rdata        (raw_rdata)
        ,.ready            (ready)
        ,.pwr_enable_b_out (pwr_enable_b_out)
    );

    qed_mem_rd_stage i_rd_stage (
         .clk       (clk)
        ,.rst       (rst)
        ,.rd_issue  (rd_issue)
        ,.raw_rdata (raw_rdata)
        ,.rsp       (rsp)
    );

endmodule

/* src/sram_bank_2048x70.sv */
`timescale 1ns/1ps

module sram_bank_2048x70 import qed_mem_pkg::*; (
     input  logic  clk
    ,input  logic  rst

    // Functional port
    ,input  logic  re
    ,input  logic  we
    ,input  addr_t addr
    ,input  half_t wdata

    // Synchronized IP reset, active low
    ,input  logic  ip_reset_b

    // Power control
    ,input  logic  isol_en
    ,input  logic  pwr_en_b_in

    ,output half_t rdata
    ,output logic  pwr_en_b_out
);

    // Storage array, kept through power gating in retention mode
    half_t mem [MEM_DEPTH];

    // Read data as it leaves the array, before isolation
    half_t rdata_q;

    // Local copy of the power enable, low means the bank is powered
    logic pwr_en_b_q;

    // The bank accepts reads and writes only when powered and out of IP reset
    logic access_ok;

    // **************************************************************************
    // Power enable handoff
    // **************************************************************************

    // The enable is held for one cycle here before the next bank sees it
    // After reset the bank comes up switched off
    always_ff @(posedge clk) begin
        if (rst) begin
            pwr_en_b_q <= 1'b1;
        end else begin
            pwr_en_b_q <= pwr_en_b_in;
        end
    end

    assign pwr_en_b_out = pwr_en_b_q;

    assign access_ok = ~pwr_en_b_q & ip_reset_b;

    // **************************************************************************
    // Array access
    // **************************************************************************

    // Both updates are non-blocking, so a read and a write to the same
    // address in one cycle returns the word that was there before the write
    always_ff @(posedge clk) begin
        if (access_ok && we) begin
            mem[addr] <= wdata;
        end
        if (access_ok && re) begin
            rdata_q <= mem[addr];
        end
    end

    // The read register holds its value between reads
    // Isolation clamps the output to zero while the bank may be unpowered
    assign rdata = isol_en ? '0 : rdata_q;

endmodule
